// File: fetchUnit.f
verilog/fetchPkg.sv
verilog/fetchStage1.sv
verilog/branchTargetBuffer.sv
verilog/branchPredictor.sv
verilog/returnStack.sv
verilog/instCache.sv
verilog/fetchUnit.sv
verification/fetchUnit_checker.sv
verification/fetchUnit_tb.sv

// File: verification/fetchUnit_tb.sv
// Table-driven testbench for the fetch unit covering fills, credits, BTB, predictor and return stack
`timescale 1ns/1ps

module fetchUnit_tb import fetchPkg::*; ();
  localparam int MAX_STEPS   = 64;
  localparam int STEP_CYCLES = 20;                 // Cycle budget per table entry

  typedef enum {OP_FILL, OP_UPDATE, OP_CREDIT, OP_REDIRECT, OP_EXPECT, OP_MISS, OP_IDLE} stepOpE;

  logic clk = 1'b0;
  logic reset, redirect_i, creditReturn_i, updateEn_i, updateTaken_i, fillEn_i;
  logic [PC_WIDTH-1:0] redirectPc_i, updatePc_i, updateTarget_i, fillAddr_i;
  brTypeE updateBrType_i;
  logic [BUNDLE_WIDTH-1:0] fillLine_i, bundle_o;
  logic bundleValid_o, missValid_o;
  logic [PC_WIDTH-1:0] bundlePc_o, predNextPc_o, missAddr_o;

  stepOpE                  opTab      [MAX_STEPS];
  string                   nameTab    [MAX_STEPS];
  logic [PC_WIDTH-1:0]     addrTab    [MAX_STEPS]; // Fill, update or redirect address, or credit count
  logic [PC_WIDTH-1:0]     targetTab  [MAX_STEPS];
  brTypeE                  typeTab    [MAX_STEPS];
  logic                    takenTab   [MAX_STEPS];
  logic [PC_WIDTH-1:0]     expPcTab   [MAX_STEPS]; // Bundle PC, or line address for a miss step
  logic [PC_WIDTH-1:0]     expNextTab [MAX_STEPS];
  logic [BUNDLE_WIDTH-1:0] lineTab    [MAX_STEPS];
  logic [BUNDLE_WIDTH-1:0] lineMem    [CACHE_LINES]; // Line each cache index should now hold
  logic [PC_WIDTH-1:0]     firePcQ    [$];           // Bundles seen by decode, oldest first
  logic [PC_WIDTH-1:0]     fireNextQ  [$];
  logic [BUNDLE_WIDTH-1:0] fireLineQ  [$];
  logic [31:0]             lfsrState = 32'hfdc6_7b4c;
  int                      numSteps  = 0;
  int                      cycleCnt  = 0;

  fetchUnit dut0 (
    .clk(clk), .reset(reset), .redirect_i(redirect_i), .redirectPc_i(redirectPc_i),
    .creditReturn_i(creditReturn_i), .updateEn_i(updateEn_i), .updatePc_i(updatePc_i),
    .updateTarget_i(updateTarget_i), .updateBrType_i(updateBrType_i),
    .updateTaken_i(updateTaken_i), .fillEn_i(fillEn_i), .fillAddr_i(fillAddr_i),
    .fillLine_i(fillLine_i), .bundleValid_o(bundleValid_o), .bundlePc_o(bundlePc_o),
    .bundle_o(bundle_o), .predNextPc_o(predNextPc_o), .missValid_o(missValid_o),
    .missAddr_o(missAddr_o)
  );

  always #20 clk = ~clk;

  // Every valid cycle is a fire, captured at the edge that consumes it
  always @(posedge clk) begin : fireMonitor
    if (!reset && bundleValid_o) begin
      firePcQ.push_back(bundlePc_o);
      fireNextQ.push_back(predNextPc_o);
      fireLineQ.push_back(bundle_o);
    end
  end

  always @(posedge clk) begin : watchdog
    cycleCnt++;
    if (cycleCnt > STEP_CYCLES * numSteps) begin
      $display("Timeout: the run took more than %0d cycles", STEP_CYCLES * numSteps);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Galois form, right shifting with the x^32 + x^22 + x^2 + x + 1 taps
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic makeLine(output logic [BUNDLE_WIDTH-1:0] line);
    for (int b = 0; b < BUNDLE_WIDTH; b++) begin
      lfsrState = lfsrNext(lfsrState);             // One step for every bit taken
      line[b]   = lfsrState[0];
    end
  endtask

  task automatic addStep(input stepOpE op, input string name, input logic [PC_WIDTH-1:0] addr,
                         input logic [PC_WIDTH-1:0] target, input brTypeE brType,
                         input logic taken, input logic [PC_WIDTH-1:0] expPc,
                         input logic [PC_WIDTH-1:0] expNext);
    opTab[numSteps]      = op;
    nameTab[numSteps]    = name;
    addrTab[numSteps]    = addr;
    targetTab[numSteps]  = target;
    typeTab[numSteps]    = brType;
    takenTab[numSteps]   = taken;
    expPcTab[numSteps]   = expPc;
    expNextTab[numSteps] = expNext;
    lineTab[numSteps]    = '0;
    if (op == OP_FILL) begin
      makeLine(lineTab[numSteps]);
    end
    numSteps++;
  endtask

  task automatic checkValue(input string name, input logic [BUNDLE_WIDTH-1:0] expected,
                            input logic [BUNDLE_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic clearPulses();
    fillEn_i       = 1'b0;
    creditReturn_i = 1'b0;
    redirect_i     = 1'b0;
    updateEn_i     = 1'b0;
  endtask

  initial begin : stimulus
    logic [PC_WIDTH-1:0]     gotPc;
    logic [PC_WIDTH-1:0]     gotNext;
    logic [BUNDLE_WIDTH-1:0] gotLine;
    reset          = 1'b1;
    redirectPc_i   = '0;
    updatePc_i     = '0;
    updateTarget_i = '0;
    updateBrType_i = BR_JUMP;
    updateTaken_i  = 1'b0;
    fillAddr_i     = '0;
    fillLine_i     = '0;
    clearPulses();
    // Sequential fetch until the four credits run out, then one returned credit
    addStep(OP_MISS,     "miss0",    32'h000, 0,       BR_JUMP,   0, 32'h000, 0);
    addStep(OP_FILL,     "fill0",    32'h000, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "seq0",     0,       0,       BR_JUMP,   0, 32'h000, 32'h010);
    addStep(OP_MISS,     "miss1",    0,       0,       BR_JUMP,   0, 32'h010, 0);
    addStep(OP_FILL,     "fill1",    32'h010, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "seq1",     0,       0,       BR_JUMP,   0, 32'h010, 32'h020);
    addStep(OP_FILL,     "fill2",    32'h020, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "seq2",     0,       0,       BR_JUMP,   0, 32'h020, 32'h030);
    addStep(OP_FILL,     "fill3",    32'h030, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "seq3",     0,       0,       BR_JUMP,   0, 32'h030, 32'h040);
    addStep(OP_FILL,     "fill4",    32'h040, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_IDLE,     "stall",    0,       0,       BR_JUMP,   0, 0,       0);
    addStep(OP_CREDIT,   "credit1",  1,       0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "resume",   0,       0,       BR_JUMP,   0, 32'h040, 32'h050);
    addStep(OP_CREDIT,   "credit4",  4,       0,       BR_JUMP,   0, 0,       0);
    // Jump in slot 2, then an unaligned redirect that starts past it
    addStep(OP_UPDATE,   "jmpUpd",   32'h058, 32'h100, BR_JUMP,   1, 0,       0);
    addStep(OP_FILL,     "fill100",  32'h100, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_FILL,     "fill50",   32'h050, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "jmpSrc",   0,       0,       BR_JUMP,   0, 32'h050, 32'h100);
    addStep(OP_EXPECT,   "jmpDst",   0,       0,       BR_JUMP,   0, 32'h100, 32'h110);
    addStep(OP_REDIRECT, "redir5c",  32'h05c, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "skipJmp",  0,       0,       BR_JUMP,   0, 32'h05c, 32'h060);
    addStep(OP_CREDIT,   "credit3a", 3,       0,       BR_JUMP,   0, 0,       0);
    // Call in slot 1, return in slot 3 of the callee bundle
    addStep(OP_UPDATE,   "callUpd",  32'h064, 32'h200, BR_CALL,   1, 0,       0);
    addStep(OP_UPDATE,   "retUpd",   32'h20c, 0,       BR_RETURN, 1, 0,       0);
    addStep(OP_FILL,     "fill200",  32'h200, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_FILL,     "fill60",   32'h060, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "call",     0,       0,       BR_JUMP,   0, 32'h060, 32'h200);
    addStep(OP_EXPECT,   "ret",      0,       0,       BR_JUMP,   0, 32'h200, 32'h068);
    addStep(OP_EXPECT,   "afterRet", 0,       0,       BR_JUMP,   0, 32'h068, 32'h070);
    addStep(OP_CREDIT,   "credit3b", 3,       0,       BR_JUMP,   0, 0,       0);
    // Conditional trained back to weakly not-taken, then taken once more
    addStep(OP_UPDATE,   "condT0",   32'h070, 32'h300, BR_COND,   1, 0,       0);
    addStep(OP_UPDATE,   "condNt",   32'h070, 32'h300, BR_COND,   0, 0,       0);
    addStep(OP_FILL,     "fill70",   32'h070, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "condWeak", 0,       0,       BR_JUMP,   0, 32'h070, 32'h080);
    addStep(OP_UPDATE,   "condT1",   32'h070, 32'h300, BR_COND,   1, 0,       0);
    addStep(OP_REDIRECT, "redir70a", 32'h070, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "condTkn",  0,       0,       BR_JUMP,   0, 32'h070, 32'h300);
    addStep(OP_REDIRECT, "redir70b", 32'h070, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_REDIRECT, "redir90",  32'h090, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_FILL,     "fill90",   32'h090, 0,       BR_JUMP,   0, 0,       0);
    addStep(OP_EXPECT,   "override", 0,       0,       BR_JUMP,   0, 32'h090, 32'h0a0);
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < numSteps; i++) begin
      @(negedge clk);
      clearPulses();
      case (opTab[i])
        OP_FILL: begin
          fillEn_i                = 1'b1;
          fillAddr_i              = addrTab[i];
          fillLine_i              = lineTab[i];
          lineMem[addrTab[i][7:4]] = lineTab[i]; // Direct mapped on PC bits 7:4
        end
        OP_UPDATE: begin
          updateEn_i     = 1'b1;
          updatePc_i     = addrTab[i];
          updateTarget_i = targetTab[i];
          updateBrType_i = typeTab[i];
          updateTaken_i  = takenTab[i];
        end
        OP_CREDIT: begin
          creditReturn_i = 1'b1;
          repeat (addrTab[i] - 1) @(negedge clk); // Held high for one credit per cycle
        end
        OP_REDIRECT: begin
          redirect_i   = 1'b1;
          redirectPc_i = addrTab[i];
        end
        OP_EXPECT: begin
          while (firePcQ.size() == 0) begin
            @(negedge clk);
          end
          gotPc   = firePcQ.pop_front();
          gotNext = fireNextQ.pop_front();
          gotLine = fireLineQ.pop_front();
          checkValue({nameTab[i], " pc"}, expPcTab[i], gotPc);
          checkValue({nameTab[i], " next pc"}, expNextTab[i], gotNext);
          checkValue({nameTab[i], " bundle"}, lineMem[expPcTab[i][7:4]], gotLine);
        end
        OP_MISS: begin
          checkValue({nameTab[i], " miss valid"}, 1, missValid_o);
          checkValue({nameTab[i], " miss addr"}, expPcTab[i], missAddr_o);
        end
        OP_IDLE: begin
          repeat (4) @(negedge clk);               // Line present but no credit left
          checkValue({nameTab[i], " fires"}, 0, firePcQ.size());
          checkValue({nameTab[i], " valid"}, 0, bundleValid_o);
        end
      endcase
    end
    repeat (2) @(negedge clk);                     // Line 0x0a0 is not cached, so nothing more leaves
    checkValue("unexpected fires", 0, firePcQ.size());
    $display("** PASS **");
    $finish;
  end

endmodule

// File: verification/fetchUnit_checker.sv
// Fetch control assertions on decode credits, redirect cycles, reset exit and PC alignment
`timescale 1ns/1ps

module fetchUnit_checker import fetchPkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                redirect_i,
  input logic [PC_WIDTH-1:0] redirectPc_i,
  input logic                creditReturn_i,
  input logic                bundleValid_i,
  input logic [PC_WIDTH-1:0] pc_i
);

  logic [CREDIT_WIDTH-1:0] creditModel;            // Credits left as seen from fires and returns alone

  always_ff @(posedge clk) begin
    if (reset) begin
      creditModel <= CREDIT_WIDTH'(FETCH_CREDITS);
    end else begin
      creditModel <= creditModel + CREDIT_WIDTH'(creditReturn_i) - CREDIT_WIDTH'(bundleValid_i);
    end
  end

  // A bundle may only leave when decode still has room for it
  noFireWithoutCredit: assert property (@(posedge clk) disable iff (reset)
    bundleValid_i |-> (creditModel != '0)) else $error("Bundle sent with no decode credit");

  // Caches and tables are empty right after reset, so nothing can be valid
  validLowAfterReset: assert property (@(posedge clk)
    reset |=> !bundleValid_i) else $error("Bundle valid in the cycle after reset");

  // The redirect holds the bundle back and its target is the next fetch PC
  noFireOnRedirect: assert property (@(posedge clk) disable iff (reset)
    redirect_i |-> !bundleValid_i ##1 (pc_i == $past(redirectPc_i)))
    else $error("Bundle sent during a redirect or redirect target not taken");

  pcWordAligned: assert property (@(posedge clk) disable iff (reset)
    pc_i[1:0] == 2'b00) else $error("Fetch PC is not word aligned"); // Instructions are 4 bytes

endmodule

bind fetchStage1 fetchUnit_checker checker0 (
  .clk(clk), .reset(reset), .redirect_i(redirect_i), .redirectPc_i(redirectPc_i),
  .creditReturn_i(creditReturn_i), .bundleValid_i(bundleValid_o), .pc_i(pc_o)
);

// File: verilog/fetchUnit.sv
// Fetch unit top joining PC control, BTB, direction predictor, return stack and instruction cache
`timescale 1ns/1ps

module fetchUnit import fetchPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    redirect_i,
  input  logic [PC_WIDTH-1:0]     redirectPc_i,
  input  logic                    creditReturn_i,
  input  logic                    updateEn_i,
  input  logic [PC_WIDTH-1:0]     updatePc_i,
  input  logic [PC_WIDTH-1:0]     updateTarget_i,
  input  brTypeE                  updateBrType_i,
  input  logic                    updateTaken_i,
  input  logic                    fillEn_i,
  input  logic [PC_WIDTH-1:0]     fillAddr_i,
  input  logic [BUNDLE_WIDTH-1:0] fillLine_i,
  output logic                    bundleValid_o,
  output logic [PC_WIDTH-1:0]     bundlePc_o,
  output logic [BUNDLE_WIDTH-1:0] bundle_o,
  output logic [PC_WIDTH-1:0]     predNextPc_o,
  output logic                    missValid_o,
  output logic [PC_WIDTH-1:0]     missAddr_o
);

  updateIf upd ();                                 // Shared by the BTB and the predictor

  logic [PC_WIDTH-1:0] pc;
  slotLookupT          slotLookup [SLOTS];
  logic [SLOTS-1:0]    slotTaken;
  logic                rasPush;
  logic [PC_WIDTH-1:0] rasPushAddr;
  logic                rasPop;
  logic [PC_WIDTH-1:0] rasTop;
  logic                cacheHit;

  assign upd.updateEn     = updateEn_i;
  assign upd.updatePc     = updatePc_i;
  assign upd.updateTarget = updateTarget_i;
  assign upd.updateBrType = updateBrType_i;
  assign upd.updateTaken  = updateTaken_i;
  assign bundlePc_o       = pc;

  fetchStage1 stage0 (
    .clk(clk), .reset(reset),
    .redirect_i(redirect_i), .redirectPc_i(redirectPc_i), .creditReturn_i(creditReturn_i),
    .slotLookup_i(slotLookup), .slotTaken_i(slotTaken), .rasTop_i(rasTop),
    .cacheHit_i(cacheHit), .pc_o(pc), .rasPush_o(rasPush), .rasPushAddr_o(rasPushAddr),
    .rasPop_o(rasPop), .bundleValid_o(bundleValid_o), .predNextPc_o(predNextPc_o)
  );

  branchTargetBuffer btb0 (
    .clk(clk), .reset(reset), .pc_i(pc), .update(upd.sink), .slotLookup_o(slotLookup)
  );

  branchPredictor bp0 (
    .clk(clk), .reset(reset), .pc_i(pc), .update(upd.sink), .slotTaken_o(slotTaken)
  );

  returnStack ras0 (
    .clk(clk), .reset(reset), .push_i(rasPush), .pushAddr_i(rasPushAddr),
    .pop_i(rasPop), .top_o(rasTop)
  );

  instCache icache0 (
    .clk(clk), .reset(reset), .pc_i(pc),
    .fillEn_i(fillEn_i), .fillAddr_i(fillAddr_i), .fillLine_i(fillLine_i),
    .bundle_o(bundle_o), .hit_o(cacheHit), .missValid_o(missValid_o), .missAddr_o(missAddr_o)
  );

endmodule

// File: verilog/instCache.sv
// Direct-mapped instruction cache of one-bundle lines, refilled through an external fill port
`timescale 1ns/1ps

module instCache import fetchPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [PC_WIDTH-1:0]     pc_i,
  input  logic                    fillEn_i,
  input  logic [PC_WIDTH-1:0]     fillAddr_i,
  input  logic [BUNDLE_WIDTH-1:0] fillLine_i,
  output logic [BUNDLE_WIDTH-1:0] bundle_o,
  output logic                    hit_o,
  output logic                    missValid_o,
  output logic [PC_WIDTH-1:0]     missAddr_o
);

  logic                       validQ [CACHE_LINES];
  logic [CACHE_TAG_WIDTH-1:0] tagQ   [CACHE_LINES];
  logic [BUNDLE_WIDTH-1:0]    lineQ  [CACHE_LINES];

  logic [CACHE_IDX_WIDTH-1:0] rdIdx;
  logic [CACHE_TAG_WIDTH-1:0] rdTag;
  logic [CACHE_IDX_WIDTH-1:0] wrIdx;
  logic [CACHE_TAG_WIDTH-1:0] wrTag;

  assign rdIdx = pc_i[LINE_OFFSET_WIDTH +: CACHE_IDX_WIDTH];
  assign rdTag = pc_i[PC_WIDTH-1 -: CACHE_TAG_WIDTH];
  assign wrIdx = fillAddr_i[LINE_OFFSET_WIDTH +: CACHE_IDX_WIDTH];
  assign wrTag = fillAddr_i[PC_WIDTH-1 -: CACHE_TAG_WIDTH];

  // Lookup is purely combinational off the fetch PC
  assign hit_o       = validQ[rdIdx] && (tagQ[rdIdx] == rdTag);
  assign bundle_o    = lineQ[rdIdx];
  assign missValid_o = !hit_o;
  assign missAddr_o  = {pc_i[PC_WIDTH-1:LINE_OFFSET_WIDTH], LINE_OFFSET_WIDTH'(0)}; // Line aligned

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < CACHE_LINES; l++) begin
        validQ[l] <= 1'b0;
      end
    end else if (fillEn_i) begin
      validQ[wrIdx] <= 1'b1;                       // Seen by lookups from the next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagQ[wrIdx]  <= wrTag;
      lineQ[wrIdx] <= fillLine_i;
    end
  end

endmodule

// File: verilog/returnStack.sv
// Circular return address stack where a push past the depth overwrites the oldest entry
`timescale 1ns/1ps

module returnStack import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_i,
  input  logic [PC_WIDTH-1:0] pushAddr_i,
  input  logic                pop_i,
  output logic [PC_WIDTH-1:0] top_o
);

  logic [PC_WIDTH-1:0]      stackQ [RAS_DEPTH];
  logic [RAS_PTR_WIDTH-1:0] topPtr;                // Index of the current top entry
  logic [RAS_CNT_WIDTH-1:0] depthCnt;              // Live entries, saturates at the depth

  // Pointer and occupancy move together
  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr   <= '0;
      depthCnt <= '0;
    end else if (push_i && !pop_i) begin
      topPtr <= topPtr + 1'b1;                     // Wraps onto the oldest slot when full
      if (depthCnt != RAS_CNT_WIDTH'(RAS_DEPTH)) begin
        depthCnt <= depthCnt + 1'b1;
      end
    end else if (pop_i && !push_i && (depthCnt != '0)) begin
      topPtr   <= topPtr - 1'b1;
      depthCnt <= depthCnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && pop_i) begin
      stackQ[topPtr] <= pushAddr_i;                // Swap the top in place
    end else if (push_i) begin
      stackQ[topPtr + 1'b1] <= pushAddr_i;
    end
  end

  assign top_o = (depthCnt == '0) ? '0 : stackQ[topPtr];

endmodule

// File: verilog/branchPredictor.sv
// Bimodal direction predictor built from 2-bit saturating counters, one per instruction word
`timescale 1ns/1ps

module branchPredictor import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [PC_WIDTH-1:0] pc_i,
  updateIf.sink               update,
  output logic [SLOTS-1:0]    slotTaken_o
);

  logic [1:0]              ctrQ [BP_ENTRIES];
  logic [BP_IDX_WIDTH-1:0] wrIdx;

  assign wrIdx = update.updatePc[BYTE_OFFSET_WIDTH +: BP_IDX_WIDTH];

  // Four neighbouring counters, one per word of the line
  always_comb begin : lookup
    logic [BP_IDX_WIDTH-1:0] rdIdx;
    rdIdx = '0;
    for (int i = 0; i < SLOTS; i++) begin
      rdIdx          = {pc_i[LINE_OFFSET_WIDTH +: BP_IDX_WIDTH - SLOT_WIDTH], SLOT_WIDTH'(i)};
      slotTaken_o[i] = ctrQ[rdIdx][1];           // Upper bit is the direction
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < BP_ENTRIES; e++) begin
        ctrQ[e] <= 2'd1;                         // Weakly not-taken
      end
    end else if (update.updateEn && (update.updateBrType == BR_COND)) begin
      if (update.updateTaken && (ctrQ[wrIdx] != 2'd3)) begin
        ctrQ[wrIdx] <= ctrQ[wrIdx] + 2'd1;
      end else if (!update.updateTaken && (ctrQ[wrIdx] != 2'd0)) begin
        ctrQ[wrIdx] <= ctrQ[wrIdx] - 2'd1;
      end
    end
  end

endmodule

// File: verilog/branchTargetBuffer.sv
// Direct-mapped branch target buffer giving type and target for all four slots of a bundle
`timescale 1ns/1ps

module branchTargetBuffer import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [PC_WIDTH-1:0] pc_i,
  updateIf.sink               update,
  output slotLookupT          slotLookup_o [SLOTS]
);

  logic                     validQ  [BTB_SETS][SLOTS];
  logic [BTB_TAG_WIDTH-1:0] tagQ    [BTB_SETS][SLOTS];
  brTypeE                   typeQ   [BTB_SETS][SLOTS];
  logic [PC_WIDTH-1:0]      targetQ [BTB_SETS][SLOTS];

  logic [BTB_IDX_WIDTH-1:0] rdSet;
  logic [BTB_TAG_WIDTH-1:0] rdTag;
  logic [BTB_IDX_WIDTH-1:0] wrSet;
  logic [SLOT_WIDTH-1:0]    wrSlot;
  logic [BTB_TAG_WIDTH-1:0] wrTag;
  logic                     wrEn;

  assign rdSet  = pc_i[LINE_OFFSET_WIDTH +: BTB_IDX_WIDTH];
  assign rdTag  = pc_i[PC_WIDTH-1 -: BTB_TAG_WIDTH];
  assign wrSet  = update.updatePc[LINE_OFFSET_WIDTH +: BTB_IDX_WIDTH];
  assign wrSlot = update.updatePc[BYTE_OFFSET_WIDTH +: SLOT_WIDTH];
  assign wrTag  = update.updatePc[PC_WIDTH-1 -: BTB_TAG_WIDTH];

  // Not-taken conditionals carry no useful target, so they are not allocated
  assign wrEn = update.updateEn && ((update.updateBrType != BR_COND) || update.updateTaken);

  always_comb begin : lookup
    for (int i = 0; i < SLOTS; i++) begin
      slotLookup_o[i].hit    = validQ[rdSet][i] && (tagQ[rdSet][i] == rdTag);
      slotLookup_o[i].brType = typeQ[rdSet][i];
      slotLookup_o[i].target = targetQ[rdSet][i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < BTB_SETS; s++) begin
        for (int w = 0; w < SLOTS; w++) begin
          validQ[s][w] <= 1'b0;
        end
      end
    end else if (wrEn) begin
      validQ[wrSet][wrSlot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      tagQ[wrSet][wrSlot]    <= wrTag;
      typeQ[wrSet][wrSlot]   <= update.updateBrType;
      targetQ[wrSet][wrSlot] <= update.updateTarget;
    end
  end

endmodule

// File: verilog/fetchStage1.sv
// Fetch control with the PC register, decode credits, next PC selection and return stack requests
`timescale 1ns/1ps

module fetchStage1 import fetchPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                redirect_i,
  input  logic [PC_WIDTH-1:0] redirectPc_i,
  input  logic                creditReturn_i,
  input  slotLookupT          slotLookup_i [SLOTS],
  input  logic [SLOTS-1:0]    slotTaken_i,
  input  logic [PC_WIDTH-1:0] rasTop_i,
  input  logic                cacheHit_i,
  output logic [PC_WIDTH-1:0] pc_o,
  output logic                rasPush_o,
  output logic [PC_WIDTH-1:0] rasPushAddr_o,
  output logic                rasPop_o,
  output logic                bundleValid_o,
  output logic [PC_WIDTH-1:0] predNextPc_o
);

  logic [PC_WIDTH-1:0]     pcQ;
  logic [CREDIT_WIDTH-1:0] creditCnt;      // Bundles decode can still accept
  logic [PC_WIDTH-1:0]     bundleBase;
  logic [PC_WIDTH-1:0]     seqPc;
  logic [SLOT_WIDTH-1:0]   wordOff;
  logic [SLOTS-1:0]        slotHitTaken;
  logic                    takenFound;
  logic [SLOT_WIDTH-1:0]   takenIdx;
  slotLookupT              takenEntry;
  logic                    fire;

  assign bundleBase = {pcQ[PC_WIDTH-1:LINE_OFFSET_WIDTH], LINE_OFFSET_WIDTH'(0)};
  assign seqPc      = bundleBase + (PC_WIDTH'(1) << LINE_OFFSET_WIDTH); // Next line
  assign wordOff    = pcQ[BYTE_OFFSET_WIDTH +: SLOT_WIDTH];

  // A slot redirects fetch when it sits at or after the PC and is predicted taken
  // Non-conditional types are always taken once the BTB knows them
  always_comb begin : slotEval
    for (int i = 0; i < SLOTS; i++) begin
      slotHitTaken[i] = (i >= int'(wordOff)) && slotLookup_i[i].hit &&
                        ((slotLookup_i[i].brType != BR_COND) || slotTaken_i[i]);
    end
  end

  // Priority pick, so the lowest taken slot ends the bundle
  always_comb begin : pickSlot
    takenFound = 1'b0;
    takenIdx   = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (slotHitTaken[i]) begin
        takenFound = 1'b1;
        takenIdx   = SLOT_WIDTH'(i);
      end
    end
  end

  assign takenEntry = slotLookup_i[takenIdx];

  always_comb begin : nextPcSel
    predNextPc_o = seqPc;                        // Fall through to the next bundle
    if (takenFound) begin
      if (takenEntry.brType == BR_RETURN) begin
        predNextPc_o = rasTop_i;                 // Returns take the stack top
      end else begin
        predNextPc_o = takenEntry.target;
      end
    end
  end

  // Valid needs the line, a free decode slot and a quiet redirect path
  assign bundleValid_o = cacheHit_i && (creditCnt != '0) && !redirect_i;
  assign fire          = bundleValid_o;

  // Stack only moves when the bundle actually leaves
  assign rasPush_o     = fire && takenFound && (takenEntry.brType == BR_CALL);
  assign rasPop_o      = fire && takenFound && (takenEntry.brType == BR_RETURN);
  assign rasPushAddr_o = bundleBase + ((PC_WIDTH'(takenIdx) + 1) << BYTE_OFFSET_WIDTH);

  always_ff @(posedge clk) begin
    if (reset) begin
      pcQ <= '0;
    end else if (redirect_i) begin
      pcQ <= redirectPc_i;                       // Execute redirect beats any prediction
    end else if (fire) begin
      pcQ <= predNextPc_o;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      creditCnt <= CREDIT_WIDTH'(FETCH_CREDITS);
    end else if (fire && !creditReturn_i) begin
      creditCnt <= creditCnt - 1'b1;
    end else if (creditReturn_i && !fire) begin
      creditCnt <= creditCnt + 1'b1;             // Spent and returned together leaves it alone
    end
  end

  assign pc_o = pcQ;

endmodule

// File: verilog/fetchPkg.sv
// Fetch package holding widths, table sizes, branch types and the predictor update interface
package fetchPkg;
  localparam int PC_WIDTH      = 32;
  localparam int INST_WIDTH    = 32;
  localparam int SLOTS         = 4;                  // Instructions per fetch bundle
  localparam int BUNDLE_WIDTH  = 128;                // One bundle is exactly one cache line
  localparam int BTB_SETS      = 16;
  localparam int BP_ENTRIES    = 64;                 // One counter per instruction word
  localparam int RAS_DEPTH     = 8;
  localparam int CACHE_LINES   = 16;
  localparam int FETCH_CREDITS = 4;                  // Decode buffer slots available at reset

  // Address fields derived from the sizes above
  localparam int BYTE_OFFSET_WIDTH = $clog2(INST_WIDTH / 8);
  localparam int LINE_OFFSET_WIDTH = $clog2(BUNDLE_WIDTH / 8);
  localparam int SLOT_WIDTH        = LINE_OFFSET_WIDTH - BYTE_OFFSET_WIDTH; // Word offset in a line
  localparam int BTB_IDX_WIDTH     = $clog2(BTB_SETS);
  localparam int BTB_TAG_WIDTH     = PC_WIDTH - LINE_OFFSET_WIDTH - BTB_IDX_WIDTH;
  localparam int BP_IDX_WIDTH      = $clog2(BP_ENTRIES);
  localparam int RAS_PTR_WIDTH     = $clog2(RAS_DEPTH);
  localparam int RAS_CNT_WIDTH     = $clog2(RAS_DEPTH + 1);
  localparam int CACHE_IDX_WIDTH   = $clog2(CACHE_LINES);
  localparam int CACHE_TAG_WIDTH   = PC_WIDTH - LINE_OFFSET_WIDTH - CACHE_IDX_WIDTH;
  localparam int CREDIT_WIDTH      = $clog2(FETCH_CREDITS + 1);

  // Control transfer kinds, encoded as the update queue sends them
  typedef enum logic [1:0] {
    BR_RETURN = 2'b00,
    BR_CALL   = 2'b01,
    BR_JUMP   = 2'b10,
    BR_COND   = 2'b11
  } brTypeE;

  // What the BTB says about one instruction slot of the bundle
  typedef struct packed {
    logic                hit;
    brTypeE              brType;
    logic [PC_WIDTH-1:0] target;
  } slotLookupT;
endpackage

`timescale 1ns/1ps

interface updateIf import fetchPkg::*; ();
  logic                updateEn;       // One resolved branch per cycle, in program order
  logic [PC_WIDTH-1:0] updatePc;
  logic [PC_WIDTH-1:0] updateTarget;
  brTypeE              updateBrType;
  logic                updateTaken;

  modport source (output updateEn, updatePc, updateTarget, updateBrType, updateTaken);
  modport sink   (input updateEn, updatePc, updateTarget, updateBrType, updateTaken);
endinterface
